/* Bender.yml */
package:
  name: dataflow_mem_ctrl

sources:
  - rtl/mem_ctrl_pkg.sv
  - rtl/fixed_priority_grant.sv
  - rtl/load_response_hold.sv
  - rtl/load_arbiter.sv
  - rtl/store_arbiter.sv
  - rtl/completion_control.sv
  - rtl/memory_controller.sv
  - target: test
    files:
      - verif/memory_controller_tb.sv

/* dataflow_mem_ctrl.f */
rtl/mem_ctrl_pkg.sv
rtl/fixed_priority_grant.sv
rtl/load_response_hold.sv
rtl/load_arbiter.sv
rtl/store_arbiter.sv
rtl/completion_control.sv
rtl/memory_controller.sv
verif/memory_controller_tb.sv

/* rtl/completion_control.sv */
`default_nettype none

module completion_control
  import mem_ctrl_pkg::*;
(
  input  logic clk,
  input  logic rst,
  // kernel start
  input  logic start_valid,
  output logic start_ready,
  // no more requests will arrive
  input  logic ctrl_end_valid,
  output logic ctrl_end_ready,
  // all work finished
  output logic end_valid,
  input  logic end_ready,
  // something still in flight in either arbiter
  input  logic requests_pending
);

  completion_state_t state_q;
  completion_state_t state_d;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_valid) begin
          state_d = RUNNING;
        end
      end
      RUNNING: begin
        // end request is only taken once the arbiters drained
        if (ctrl_end_valid && !requests_pending) begin
          state_d = END_ACK;
        end
      end
      END_ACK: begin
        state_d = end_ready ? IDLE : DONE;
      end
      DONE: begin
        if (end_ready) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  assign start_ready    = (state_q == IDLE);
  assign ctrl_end_ready = (state_q == END_ACK);
  assign end_valid      = (state_q == END_ACK) || (state_q == DONE);

  // end is a proper valid, held until taken
  end_held_a: assert property (
    @(posedge clk) disable iff (rst)
    end_valid && !end_ready |=> end_valid
  ) else $error("completion_control: end_valid dropped before end_ready");

endmodule

`default_nettype wire

/* rtl/fixed_priority_grant.sv */
`default_nettype none

module fixed_priority_grant #(
  parameter int NUM_PORTS = 2
) (
  input  logic [NUM_PORTS-1:0] req,
  input  logic [NUM_PORTS-1:0] consumer_ready,
  output logic [NUM_PORTS-1:0] grant
);

  // a port may only win if someone downstream can take its result
  logic [NUM_PORTS-1:0] eligible;

  assign eligible = req & consumer_ready;

  // scan upward, first eligible port wins
  always_comb begin
    logic taken;
    taken = 1'b0;
    grant = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (eligible[i] && !taken) begin
        grant[i] = 1'b1;
      end
      taken = taken | eligible[i];
    end
  end

  // at most one port drives the memory port in any cycle
  grant_onehot_a: assert final ($onehot0(grant))
    else $error("fixed_priority_grant: more than one port granted (%b)", grant);

endmodule

`default_nettype wire

/* rtl/load_arbiter.sv */
`default_nettype none

module load_arbiter
  import mem_ctrl_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // producers
  input  logic [NUM_PORTS-1:0] load_valid,
  input  addr_t                load_addr [NUM_PORTS],
  output logic [NUM_PORTS-1:0] load_ready,
  // consumers
  input  logic [NUM_PORTS-1:0] load_data_ready,
  output logic [NUM_PORTS-1:0] load_data_valid,
  output data_t                load_data [NUM_PORTS],
  // memory read port
  output logic                 read_enable,
  output addr_t                read_address,
  input  data_t                read_data
);

  logic [NUM_PORTS-1:0] grant;

  fixed_priority_grant #(
    .NUM_PORTS(NUM_PORTS)
  ) u_grant (
    .req           (load_valid),
    .consumer_ready(load_data_ready),
    .grant         (grant)
  );

  // grant already includes the consumer's ready
  assign load_ready  = grant;
  assign read_enable = |grant;

  // winner's address onto the read port
  always_comb begin
    read_address = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant[i]) begin
        read_address = load_addr[i];
      end
    end
  end

  load_response_hold #(
    .NUM_PORTS(NUM_PORTS)
  ) u_hold (
    .clk           (clk),
    .rst           (rst),
    .grant         (grant),
    .read_data     (read_data),
    .consumer_ready(load_data_ready),
    .data_valid    (load_data_valid),
    .data          (load_data)
  );

endmodule

`default_nettype wire

/* rtl/load_response_hold.sv */
`default_nettype none

module load_response_hold
  import mem_ctrl_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic [NUM_PORTS-1:0] grant,
  input  data_t                read_data,
  input  logic [NUM_PORTS-1:0] consumer_ready,
  output logic [NUM_PORTS-1:0] data_valid,
  output data_t                data [NUM_PORTS]
);

  // which port owns the word coming back from memory this cycle
  logic [NUM_PORTS-1:0] grant_q;

  // last word returned to each port
  data_t hold_q [NUM_PORTS];

  always_ff @(posedge clk) begin
    if (rst) begin
      grant_q    <= '0;
      data_valid <= '0;
    end else begin
      grant_q <= grant;
      for (int i = 0; i < NUM_PORTS; i++) begin
        // a new grant wins over consumption in the same cycle
        if (grant[i]) begin
          data_valid[i] <= 1'b1;
        end else if (consumer_ready[i]) begin
          data_valid[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant_q[i]) begin
        hold_q[i] <= read_data;
      end
    end
  end

  // bypass in the arrival cycle, held copy afterwards
  always_comb begin
    for (int i = 0; i < NUM_PORTS; i++) begin
      data[i] = grant_q[i] ? read_data : hold_q[i];
    end
  end

  for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port_chk
    // a pending result is never dropped under back-pressure
    valid_held_a: assert property (
      @(posedge clk) disable iff (rst)
      data_valid[g] && !consumer_ready[g] |=> data_valid[g]
    ) else $error("load_response_hold: port %0d result dropped", g);

    // and its word does not change while it waits
    data_stable_a: assert property (
      @(posedge clk) disable iff (rst)
      data_valid[g] && !consumer_ready[g] |=> $stable(data[g])
    ) else $error("load_response_hold: port %0d data changed while stalled", g);
  end

endmodule

`default_nettype wire

/* rtl/mem_ctrl_pkg.sv */
`default_nettype none

package mem_ctrl_pkg;

  // memory geometry
  parameter int ADDR_W = 10;
  parameter int DATA_W = 32;

  // one memory address
  typedef logic [ADDR_W-1:0] addr_t;

  // one memory word
  typedef logic [DATA_W-1:0] data_t;

  // kernel run phases seen by the completion handshake
  typedef enum logic [1:0] {
    IDLE,
    RUNNING,
    END_ACK,
    DONE
  } completion_state_t;

endpackage

`default_nettype wire

/* rtl/memory_controller.sv */
`default_nettype none

module memory_controller
  import mem_ctrl_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  input  logic                 clk,
  input  logic                 rst,
  // load producers
  input  logic [NUM_PORTS-1:0] load_valid,
  input  addr_t                load_addr [NUM_PORTS],
  output logic [NUM_PORTS-1:0] load_ready,
  // load consumers
  input  logic [NUM_PORTS-1:0] load_data_ready,
  output logic [NUM_PORTS-1:0] load_data_valid,
  output data_t                load_data [NUM_PORTS],
  // store producers
  input  logic [NUM_PORTS-1:0] store_valid,
  input  addr_t                store_addr [NUM_PORTS],
  input  data_t                store_data [NUM_PORTS],
  output logic [NUM_PORTS-1:0] store_ready,
  // store acknowledge
  input  logic [NUM_PORTS-1:0] store_done_ready,
  output logic [NUM_PORTS-1:0] store_done_valid,
  // memory read port
  output logic                 read_enable,
  output addr_t                read_address,
  input  data_t                read_data,
  // memory write port
  output logic                 write_enable,
  output addr_t                write_address,
  output data_t                write_data,
  // completion handshakes
  input  logic                 start_valid,
  output logic                 start_ready,
  input  logic                 ctrl_end_valid,
  output logic                 ctrl_end_ready,
  output logic                 end_valid,
  input  logic                 end_ready
);

  logic requests_pending;

  load_arbiter #(
    .NUM_PORTS(NUM_PORTS)
  ) u_load_arb (
    .clk            (clk),
    .rst            (rst),
    .load_valid     (load_valid),
    .load_addr      (load_addr),
    .load_ready     (load_ready),
    .load_data_ready(load_data_ready),
    .load_data_valid(load_data_valid),
    .load_data      (load_data),
    .read_enable    (read_enable),
    .read_address   (read_address),
    .read_data      (read_data)
  );

  store_arbiter #(
    .NUM_PORTS(NUM_PORTS)
  ) u_store_arb (
    .store_valid     (store_valid),
    .store_addr      (store_addr),
    .store_data      (store_data),
    .store_ready     (store_ready),
    .store_done_ready(store_done_ready),
    .store_done_valid(store_done_valid),
    .write_enable    (write_enable),
    .write_address   (write_address),
    .write_data      (write_data)
  );

  // load results still waiting count as outstanding work
  assign requests_pending = (|load_valid) | (|store_valid) | (|load_data_valid);

  completion_control u_completion (
    .clk             (clk),
    .rst             (rst),
    .start_valid     (start_valid),
    .start_ready     (start_ready),
    .ctrl_end_valid  (ctrl_end_valid),
    .ctrl_end_ready  (ctrl_end_ready),
    .end_valid       (end_valid),
    .end_ready       (end_ready),
    .requests_pending(requests_pending)
  );

endmodule

`default_nettype wire

/* rtl/store_arbiter.sv */
`default_nettype none

module store_arbiter
  import mem_ctrl_pkg::*;
#(
  parameter int NUM_PORTS = 2
) (
  // producers
  input  logic [NUM_PORTS-1:0] store_valid,
  input  addr_t                store_addr [NUM_PORTS],
  input  data_t                store_data [NUM_PORTS],
  output logic [NUM_PORTS-1:0] store_ready,
  // consumers of the store acknowledge
  input  logic [NUM_PORTS-1:0] store_done_ready,
  output logic [NUM_PORTS-1:0] store_done_valid,
  // memory write port
  output logic                 write_enable,
  output addr_t                write_address,
  output data_t                write_data
);

  logic [NUM_PORTS-1:0] grant;

  fixed_priority_grant #(
    .NUM_PORTS(NUM_PORTS)
  ) u_grant (
    .req           (store_valid),
    .consumer_ready(store_done_ready),
    .grant         (grant)
  );

  // write lands on the next edge, so both sides are acked now
  assign store_ready      = grant;
  assign store_done_valid = grant;
  assign write_enable     = |grant;

  // address and data of the winner
  always_comb begin
    write_address = '0;
    write_data    = '0;
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (grant[i]) begin
        write_address = store_addr[i];
        write_data    = store_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* verif/memory_controller_tb.sv */
`default_nettype none

module memory_controller_tb
  import mem_ctrl_pkg::*;
;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_PORTS = 2;
  localparam int DIRECTED = NUM_PORTS * 4;
  localparam int RANDOM_CYCLES = 1500;
  // directed part and random part need about 1600 cycles, three times that as margin
  localparam int MAX_CYCLES = 5000;

  logic clk = 1'b0;
  logic rst;
  logic [NUM_PORTS-1:0] load_valid, load_ready, load_data_ready, load_data_valid;
  logic [NUM_PORTS-1:0] store_valid, store_ready, store_done_ready, store_done_valid;
  addr_t load_addr [NUM_PORTS];
  addr_t store_addr [NUM_PORTS];
  data_t store_data [NUM_PORTS];
  data_t load_data [NUM_PORTS];
  logic read_enable, write_enable;
  addr_t read_address, write_address;
  data_t read_data, write_data;
  logic start_valid, start_ready, ctrl_end_valid, ctrl_end_ready, end_valid, end_ready;

  // memory model and the testbench's own copy of it
  data_t mem [2**ADDR_W];
  data_t shadow [2**ADDR_W];

  // expected load side and completion state
  logic [NUM_PORTS-1:0] exp_valid;
  data_t exp_data [NUM_PORTS];
  completion_state_t exp_state;

  integer seed = 32'h2b49;
  int cycle_count = 0;
  int check_count = 0;
  int error_count = 0;
  addr_t addrs [DIRECTED];
  data_t words [DIRECTED];
  data_t held_word;

  memory_controller #(.NUM_PORTS(NUM_PORTS)) UUT (.*);

  always #5 clk = ~clk;

  always @(posedge clk) begin
    if (write_enable) mem[write_address] <= write_data;
    if (read_enable) read_data <= mem[read_address];
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  // lowest index that requests and has a ready consumer
  function automatic logic [NUM_PORTS-1:0] expected_grant(input logic [NUM_PORTS-1:0] req,
                                                          input logic [NUM_PORTS-1:0] rdy);
    for (int i = 0; i < NUM_PORTS; i++) begin
      if (req[i] && rdy[i]) return NUM_PORTS'(1) << i;
    end
    return '0;
  endfunction

  function automatic data_t expected_word(input addr_t a);
    return shadow[a];
  endfunction

  task automatic check_data(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_mask(input logic [NUM_PORTS-1:0] got, input logic [NUM_PORTS-1:0] exp,
                            input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  // outputs are stable at the falling edge
  always @(negedge clk) begin : compare
    logic [NUM_PORTS-1:0] lg;
    logic [NUM_PORTS-1:0] sg;
    logic pending;
    if (rst) begin
      exp_valid = '0;
      exp_state = IDLE;
    end else begin
      lg = expected_grant(load_valid, load_data_ready);
      sg = expected_grant(store_valid, store_done_ready);
      check_mask(load_ready, lg, "load_ready");
      check_bit(read_enable, |lg, "read_enable");
      check_mask(store_ready, sg, "store_ready");
      check_mask(store_done_valid, sg, "store_done_valid");
      check_bit(write_enable, |sg, "write_enable");
      check_mask(load_data_valid, exp_valid, "load_data_valid");
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (exp_valid[i]) check_data(load_data[i], exp_data[i], $sformatf("load_data[%0d]", i));
        if (lg[i]) check_addr(read_address, load_addr[i], "read_address");
        if (sg[i]) begin
          check_addr(write_address, store_addr[i], "write_address");
          check_data(write_data, store_data[i], "write_data");
        end
      end
      check_bit(start_ready, exp_state == IDLE, "start_ready");
      check_bit(ctrl_end_ready, exp_state == END_ACK, "ctrl_end_ready");
      check_bit(end_valid, exp_state == END_ACK || exp_state == DONE, "end_valid");
      // advance the model to the next edge
      pending = (|load_valid) || (|store_valid) || (|exp_valid);
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (lg[i]) begin
          exp_valid[i] = 1'b1;
          exp_data[i] = expected_word(load_addr[i]);
        end else if (load_data_ready[i]) begin
          exp_valid[i] = 1'b0;
        end
      end
      // read sees the old word, so the write goes in after
      for (int i = 0; i < NUM_PORTS; i++) begin
        if (sg[i]) shadow[store_addr[i]] = store_data[i];
      end
      case (exp_state)
        IDLE: if (start_valid) exp_state = RUNNING;
        RUNNING: if (ctrl_end_valid && !pending) exp_state = END_ACK;
        END_ACK: exp_state = end_ready ? IDLE : DONE;
        default: if (end_ready) exp_state = IDLE;
      endcase
    end
  end

  task automatic store_word(input int p, input addr_t a, input data_t d);
    store_valid[p] = 1'b1;
    store_addr[p] = a;
    store_data[p] = d;
    do @(negedge clk); while (!store_ready[p]);
    @(posedge clk);
    #1;
    store_valid[p] = 1'b0;
  endtask

  task automatic load_word(input int p, input addr_t a, input data_t exp);
    load_valid[p] = 1'b1;
    load_addr[p] = a;
    do @(negedge clk); while (!load_ready[p]);
    @(posedge clk);
    #1;
    load_valid[p] = 1'b0;
    @(negedge clk);
    check_bit(load_data_valid[p], 1'b1, "load result valid");
    check_data(load_data[p], exp, "load result word");
    @(posedge clk);
    #1;
  endtask

  initial begin
    for (int a = 0; a < 2**ADDR_W; a++) begin
      mem[a] = data_t'(a * 32'h9e37_79b1) ^ data_t'(a);
      shadow[a] = mem[a];
    end
    rst = 1'b1;
    read_data = '0;
    load_valid = '0;
    load_data_ready = '1;
    store_valid = '0;
    store_done_ready = '1;
    for (int i = 0; i < NUM_PORTS; i++) begin
      load_addr[i] = '0;
      store_addr[i] = '0;
      store_data[i] = '0;
    end
    start_valid = 1'b0;
    ctrl_end_valid = 1'b0;
    end_ready = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    start_valid = 1'b1;
    do @(negedge clk); while (!start_ready);
    @(posedge clk);
    #1;
    start_valid = 1'b0;

    // distinct addresses so every load has one known word
    for (int j = 0; j < DIRECTED; j++) begin
      addrs[j] = addr_t'(64 + j * 8 + ($random(seed) & 7));
      words[j] = data_t'($random(seed));
      store_word(j % NUM_PORTS, addrs[j], words[j]);
    end
    for (int p = 0; p < NUM_PORTS; p++) begin
      for (int j = 0; j < DIRECTED; j++) load_word(p, addrs[j], words[j]);
    end

    // random traffic on a small address range
    repeat (RANDOM_CYCLES) begin
      @(posedge clk);
      #1;
      load_valid = NUM_PORTS'($random(seed));
      store_valid = NUM_PORTS'($random(seed));
      load_data_ready = NUM_PORTS'($random(seed));
      store_done_ready = NUM_PORTS'($random(seed));
      for (int i = 0; i < NUM_PORTS; i++) begin
        load_addr[i] = addr_t'($random(seed) & 15);
        store_addr[i] = addr_t'($random(seed) & 15);
        store_data[i] = data_t'($random(seed));
      end
    end
    @(posedge clk);
    #1;
    load_valid = '0;
    store_valid = '0;
    load_data_ready = '1;
    store_done_ready = '1;
    repeat (2) @(posedge clk);
    #1;

    // one load result left waiting at its consumer
    load_valid[0] = 1'b1;
    load_addr[0] = addrs[0];
    do @(negedge clk); while (!load_ready[0]);
    held_word = expected_word(addrs[0]);
    @(posedge clk);
    #1;
    load_valid[0] = 1'b0;
    load_data_ready[0] = 1'b0;
    ctrl_end_valid = 1'b1;
    repeat (4) begin
      @(negedge clk);
      check_bit(ctrl_end_ready, 1'b0, "ctrl_end_ready while pending");
      check_bit(load_data_valid[0], 1'b1, "held load valid");
      check_data(load_data[0], held_word, "held load word");
    end
    @(posedge clk);
    #1;
    load_data_ready[0] = 1'b1;
    do @(negedge clk); while (!ctrl_end_ready);
    @(posedge clk);
    #1;
    ctrl_end_valid = 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_bit(end_valid, 1'b1, "end_valid held");
      check_bit(start_ready, 1'b0, "start_ready before end");
    end
    @(posedge clk);
    #1;
    end_ready = 1'b1;
    @(posedge clk);
    #1;
    end_ready = 1'b0;
    @(negedge clk);
    check_bit(start_ready, 1'b1, "start_ready after end");
    check_bit(end_valid, 1'b0, "end_valid after end");

    repeat (2) @(negedge clk);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
